// File: dadda_cfg.svh
`ifndef DADDA_CFG_SVH
`define DADDA_CFG_SVH

// multiplier sizes
`define DADDA_WIDTH       16
`define DADDA_PROD_WIDTH  32
`define DADDA_STAGES      6

// wishbone side, byte addressed
`define WB_ADDR_WIDTH     4
`define WB_DATA_WIDTH     32

// word addresses, taken from adr[3:2]
`define REG_OPERANDS      2'd0
`define REG_PRODUCT       2'd1
`define REG_STATUS        2'd2

`endif

// File: dadda_pkg.sv
`include "dadda_cfg.svh"

package dadda_pkg;

    typedef logic [`DADDA_WIDTH-1:0]      operand_t;
    typedef logic [`DADDA_PROD_WIDTH-1:0] product_t;

    typedef logic [`WB_ADDR_WIDTH-1:0]    wb_addr_t;
    typedef logic [`WB_DATA_WIDTH-1:0]    wb_data_t;

    // bus slave handshake
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_ACK
    } wb_state_t;

endpackage

// File: mul_core_if.sv
`timescale 1ns/1ps

interface mul_core_if;

    // start and done are single cycle pulses
    logic                start;
    dadda_pkg::operand_t a;
    dadda_pkg::operand_t b;
    dadda_pkg::product_t product;
    logic                done;

    modport slave (
        output start,
        output a,
        output b,
        input  product,
        input  done
    );

    modport core (
        input  start,
        input  a,
        input  b,
        output product,
        output done
    );

endinterface

// File: partial_product_gen.sv
`timescale 1ns/1ps
`include "dadda_cfg.svh"

module partial_product_gen (
    input  dadda_pkg::operand_t                            a,
    input  dadda_pkg::operand_t                            b,
    output logic [`DADDA_PROD_WIDTH-1:0][`DADDA_WIDTH-1:0] pp_cols
);

    localparam int w = `DADDA_WIDTH;

    // bits of weight k packed from bit 0 up, unused bits stay zero
    always_comb begin
        pp_cols = '0;
        for (int i = 0; i < w; i++) begin
            for (int j = 0; j < w; j++) begin
                // columns past the middle count rows from the top operand bit
                pp_cols[i + j][(i + j < w) ? i : w - 1 - j] = a[i] & b[j];
            end
        end
    end

endmodule

// File: dadda_reduce_stage.sv
`timescale 1ns/1ps
`include "dadda_cfg.svh"

module dadda_reduce_stage #(
    parameter int target_height = 2,
    parameter int stage_idx     = `DADDA_STAGES - 1
) (
    input  logic [`DADDA_PROD_WIDTH-1:0][`DADDA_WIDTH-1:0] cols_in,
    output logic [`DADDA_PROD_WIDTH-1:0][`DADDA_WIDTH-1:0] cols_out
);

    localparam int ncols = `DADDA_PROD_WIDTH;
    localparam int depth = `DADDA_WIDTH;

    // dadda sequence 2, 3, 4, 6, 9, 13 counted back from the last stage
    function automatic int prior_target(input int s);
        int d;
        d = 2;
        for (int i = `DADDA_STAGES - 1; i > s; i--) begin
            d = (d * 3) / 2;
        end
        return d;
    endfunction

    // sel 0 full adders, 1 half adders, 2 carries arriving from column k-1
    function automatic int col_info(input int sel, input int k);
        int h [ncols];
        int fa;
        int ha;
        int cin;
        int excess;
        int tgt;
        int result;
        result = 0;
        for (int c = 0; c < ncols; c++) begin
            if (c < depth) begin
                h[c] = c + 1;
            end else if (c < 2 * depth - 1) begin
                h[c] = 2 * depth - 1 - c;
            end else begin
                h[c] = 0;
            end
        end
        // replay every stage up to this one, low column first
        for (int s = 0; s <= stage_idx; s++) begin
            tgt = (s == stage_idx) ? target_height : prior_target(s);
            cin = 0;
            for (int c = 0; c < ncols; c++) begin
                excess = h[c] + cin - tgt;
                fa = (excess > 0) ? excess / 2 : 0;
                ha = (excess > 0) ? excess % 2 : 0;
                if (s == stage_idx && c == k) begin
                    case (sel)
                        0:       result = fa;
                        1:       result = ha;
                        default: result = cin;
                    endcase
                end
                h[c] = h[c] - 2 * fa - ha + cin;
                cin = fa + ha;
            end
        end
        return result;
    endfunction

    logic [depth-1:0] carry_bits [ncols];

    assign carry_bits[0] = '0;

    for (genvar k = 0; k < ncols; k++) begin : g_col
        localparam int n_fa   = col_info(0, k);
        localparam int n_ha   = col_info(1, k);
        localparam int c_in   = col_info(2, k);
        localparam int n_used = 3 * n_fa + 2 * n_ha;
        localparam int n_sum  = n_fa + n_ha;

        logic [depth-1:0] sums;
        logic [depth-1:0] carries;

        always_comb begin
            sums = '0;
            carries = '0;
            for (int f = 0; f < n_fa; f++) begin
                sums[f] = cols_in[k][3*f] ^ cols_in[k][3*f+1] ^ cols_in[k][3*f+2];
                carries[f] = (cols_in[k][3*f] & cols_in[k][3*f+1])
                           | (cols_in[k][3*f+1] & cols_in[k][3*f+2])
                           | (cols_in[k][3*f+2] & cols_in[k][3*f]);
            end
            for (int j = 0; j < n_ha; j++) begin
                sums[n_fa+j] = cols_in[k][3*n_fa+2*j] ^ cols_in[k][3*n_fa+2*j+1];
                carries[n_fa+j] = cols_in[k][3*n_fa+2*j] & cols_in[k][3*n_fa+2*j+1];
            end
        end

        // sums, then carries from below, then the bits no adder touched
        assign cols_out[k] = sums
                           | (carry_bits[k] << n_sum)
                           | ((cols_in[k] >> n_used) << (n_sum + c_in));

        if (k < ncols - 1) begin : g_carry
            assign carry_bits[k+1] = carries;
        end
    end

endmodule

// File: dadda_tree.sv
`timescale 1ns/1ps
`include "dadda_cfg.svh"

module dadda_tree (
    input  logic [`DADDA_PROD_WIDTH-1:0][`DADDA_WIDTH-1:0] pp_cols,
    output dadda_pkg::product_t                            row_sum,
    output dadda_pkg::product_t                            row_carry
);

    localparam int targets [`DADDA_STAGES] = '{13, 9, 6, 4, 3, 2};

    logic [`DADDA_PROD_WIDTH-1:0][`DADDA_WIDTH-1:0] stage_cols [`DADDA_STAGES+1];

    assign stage_cols[0] = pp_cols;

    for (genvar s = 0; s < `DADDA_STAGES; s++) begin : g_stage
        dadda_reduce_stage #(
            .target_height (targets[s]),
            .stage_idx     (s)
        ) dadda_reduce_stage_inst (
            .cols_in  (stage_cols[s]),
            .cols_out (stage_cols[s+1])
        );
    end

    // columns are at most two high here, empty slots already read zero
    always_comb begin
        for (int k = 0; k < `DADDA_PROD_WIDTH; k++) begin
            row_sum[k]   = stage_cols[`DADDA_STAGES][k][0];
            row_carry[k] = stage_cols[`DADDA_STAGES][k][1];
        end
    end

endmodule

// File: cla_adder.sv
`timescale 1ns/1ps

module cla_adder #(
    parameter int width = 32
) (
    input  logic [width-1:0] x,
    input  logic [width-1:0] y,
    output logic [width-1:0] sum
);

    localparam int n_groups = width / 4;

    logic [width-1:0]  gen;
    logic [width-1:0]  prop;
    logic [width-1:0]  carry;
    // last entry is the carry out, never needed for a product
    logic [n_groups:0] group_carry;

    assign gen            = x & y;
    assign prop           = x ^ y;
    assign group_carry[0] = 1'b0;

    for (genvar grp = 0; grp < n_groups; grp++) begin : g_group
        logic [3:0] g;
        logic [3:0] p;
        logic       c0;

        assign g  = gen[4*grp +: 4];
        assign p  = prop[4*grp +: 4];
        assign c0 = group_carry[grp];

        // lookahead inside the group
        assign carry[4*grp]     = c0;
        assign carry[4*grp + 1] = g[0] | (p[0] & c0);
        assign carry[4*grp + 2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & c0);
        assign carry[4*grp + 3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                                | (p[2] & p[1] & p[0] & c0);

        // group carries ripple to the next group
        assign group_carry[grp + 1] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
                                    | (p[3] & p[2] & p[1] & g[0])
                                    | (p[3] & p[2] & p[1] & p[0] & c0);
    end

    assign sum = prop ^ carry;

endmodule

// File: dadda_mult_core.sv
`timescale 1ns/1ps
`include "dadda_cfg.svh"

module dadda_mult_core (
    input logic      clk,
    input logic      rst_n,
    mul_core_if.core core
);

    logic [`DADDA_PROD_WIDTH-1:0][`DADDA_WIDTH-1:0] pp_cols;

    dadda_pkg::product_t row_sum;
    dadda_pkg::product_t row_carry;
    dadda_pkg::product_t row_sum_q;
    dadda_pkg::product_t row_carry_q;
    dadda_pkg::product_t sum;
    dadda_pkg::product_t product_q;
    logic                valid_q;
    logic                done_q;

    partial_product_gen partial_product_gen_inst (
        .a       (core.a),
        .b       (core.b),
        .pp_cols (pp_cols)
    );

    dadda_tree dadda_tree_inst (
        .pp_cols   (pp_cols),
        .row_sum   (row_sum),
        .row_carry (row_carry)
    );

    cla_adder #(
        .width (`DADDA_PROD_WIDTH)
    ) cla_adder_inst (
        .x   (row_sum_q),
        .y   (row_carry_q),
        .sum (sum)
    );

    // one item per stage, a start every cycle is fine
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            valid_q <= core.start;
            done_q  <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        if (core.start) begin
            row_sum_q   <= row_sum;
            row_carry_q <= row_carry;
        end
        if (valid_q) begin
            product_q <= sum;
        end
    end

    assign core.product = product_q;
    assign core.done    = done_q;

endmodule

// File: dadda_wb_slave.sv
`timescale 1ns/1ps
`include "dadda_cfg.svh"

module dadda_wb_slave (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  dadda_pkg::wb_addr_t wb_adr,
    input  dadda_pkg::wb_data_t wb_wdat,
    output dadda_pkg::wb_data_t wb_rdat,
    output logic                wb_ack,
    mul_core_if.slave           core
);

    dadda_pkg::wb_state_t state;
    dadda_pkg::operand_t  op_a;
    dadda_pkg::operand_t  op_b;
    dadda_pkg::product_t  product_q;
    logic                 busy_q;
    logic                 done_q;
    logic                 start_q;

    logic       req;
    logic [1:0] word;
    logic       op_write;
    logic       prod_read;
    logic       stall;
    logic       accept;

    assign req       = wb_cyc && wb_stb;
    assign word      = wb_adr[3:2];
    assign op_write  = wb_we && (word == `REG_OPERANDS);
    assign prod_read = !wb_we && (word == `REG_PRODUCT);

    // done clears busy at this edge, so that cycle is already free
    assign stall  = busy_q && !core.done;
    assign accept = req && (state != dadda_pkg::ST_ACK)
                 && !(stall && (op_write || prod_read));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= dadda_pkg::ST_IDLE;
            start_q   <= 1'b0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            op_a      <= '0;
            op_b      <= '0;
            product_q <= '0;
        end else begin
            start_q <= accept && op_write;

            case (state)
                dadda_pkg::ST_IDLE: begin
                    if (accept) begin
                        state <= dadda_pkg::ST_ACK;
                    end else if (req) begin
                        state <= dadda_pkg::ST_WAIT;
                    end
                end
                dadda_pkg::ST_WAIT: begin
                    if (accept) begin
                        state <= dadda_pkg::ST_ACK;
                    end else if (!req) begin
                        // master gave up the cycle
                        state <= dadda_pkg::ST_IDLE;
                    end
                end
                dadda_pkg::ST_ACK: state <= dadda_pkg::ST_IDLE;
                default:           state <= dadda_pkg::ST_IDLE;
            endcase

            if (accept && op_write) begin
                op_a   <= wb_wdat[`DADDA_WIDTH-1:0];
                op_b   <= wb_wdat[2*`DADDA_WIDTH-1:`DADDA_WIDTH];
                busy_q <= 1'b1;
                done_q <= 1'b0;
            end else if (core.done) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end

            if (core.done) begin
                product_q <= core.product;
            end
        end
    end

    // address still held by the master while ack is up
    always_comb begin
        case (word)
            `REG_OPERANDS: wb_rdat = {op_b, op_a};
            `REG_PRODUCT:  wb_rdat = product_q;
            `REG_STATUS:   wb_rdat = {{(`WB_DATA_WIDTH - 2){1'b0}}, done_q, busy_q};
            default:       wb_rdat = '0;
        endcase
    end

    assign wb_ack     = (state == dadda_pkg::ST_ACK);
    assign core.start = start_q;
    assign core.a     = op_a;
    assign core.b     = op_b;

endmodule

// File: dadda_mult_top.sv
`timescale 1ns/1ps

module dadda_mult_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  dadda_pkg::wb_addr_t wb_adr,
    input  dadda_pkg::wb_data_t wb_wdat,
    output dadda_pkg::wb_data_t wb_rdat,
    output logic                wb_ack
);

    mul_core_if mul_core_if_inst ();

    dadda_wb_slave dadda_wb_slave_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_wdat (wb_wdat),
        .wb_rdat (wb_rdat),
        .wb_ack  (wb_ack),
        .core    (mul_core_if_inst.slave)
    );

    dadda_mult_core dadda_mult_core_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .core  (mul_core_if_inst.core)
    );

endmodule

// File: tb_dadda_mult.sv
`timescale 1ns/1ps
`include "dadda_cfg.svh"

module tb_dadda_mult;

    localparam int n_random      = 200;
    localparam int cycles_per_op = 12;
    // random ops twice over, plus the directed tests
    localparam int max_cycles    = 2 * n_random * cycles_per_op + 200;
    localparam int ack_limit     = 20;

    localparam dadda_pkg::wb_addr_t adr_operands = {`REG_OPERANDS, 2'b00};
    localparam dadda_pkg::wb_addr_t adr_product  = {`REG_PRODUCT, 2'b00};
    localparam dadda_pkg::wb_addr_t adr_status   = {`REG_STATUS, 2'b00};
    localparam dadda_pkg::wb_addr_t adr_unused   = 4'hc;

    localparam dadda_pkg::wb_data_t status_busy = 32'h1;
    localparam dadda_pkg::wb_data_t status_done = 32'h2;

    logic                clk;
    logic                rst_n;
    logic                wb_cyc;
    logic                wb_stb;
    logic                wb_we;
    dadda_pkg::wb_addr_t wb_adr;
    dadda_pkg::wb_data_t wb_wdat;
    dadda_pkg::wb_data_t wb_rdat;
    logic                wb_ack;

    int     errors;
    int     checks;
    int     errors_base;
    int     cycle_count;
    integer seed;

    dadda_mult_top dadda_mult_top_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_cyc  (wb_cyc),
        .wb_stb  (wb_stb),
        .wb_we   (wb_we),
        .wb_adr  (wb_adr),
        .wb_wdat (wb_wdat),
        .wb_rdat (wb_rdat),
        .wb_ack  (wb_ack)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == max_cycles) begin
            $display("run stopped after %0d cycles without reaching the end", max_cycles);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic check_product(input string name, input dadda_pkg::product_t expected,
                                 input dadda_pkg::product_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic check_data(input string name, input dadda_pkg::wb_data_t expected,
                              input dadda_pkg::wb_data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %s expected %h got %h", name, expected, actual);
        end
    endtask

    // called on a falling edge, returns on the falling edge that shows ack
    task automatic bus_cycle(input logic we, input dadda_pkg::wb_addr_t adr,
                             input dadda_pkg::wb_data_t wdat,
                             output dadda_pkg::wb_data_t rdat);
        int   waited;
        logic acked;
        waited  = 0;
        acked   = 1'b0;
        rdat    = '0;
        wb_cyc  = 1'b1;
        wb_stb  = 1'b1;
        wb_we   = we;
        wb_adr  = adr;
        wb_wdat = wdat;
        while (!acked && waited < ack_limit) begin
            @(negedge clk);
            waited++;
            acked = wb_ack;
        end
        rdat   = wb_rdat;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!acked) begin
            errors++;
            $display("no ack from the slave within %0d cycles, address %h", ack_limit, adr);
        end
    endtask

    task automatic wb_write(input dadda_pkg::wb_addr_t adr, input dadda_pkg::wb_data_t data);
        dadda_pkg::wb_data_t unused;
        bus_cycle(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input dadda_pkg::wb_addr_t adr, output dadda_pkg::wb_data_t data);
        bus_cycle(1'b0, adr, '0, data);
    endtask

    task automatic report_test(input string name);
        $display("test %s finished with %0d errors", name, errors - errors_base);
        errors_base = errors;
    endtask

    // write both operands, read the product back and compare with a times b
    task automatic multiply_and_check(input dadda_pkg::operand_t a,
                                      input dadda_pkg::operand_t b);
        dadda_pkg::wb_data_t rdat;
        dadda_pkg::product_t expected;
        expected = dadda_pkg::product_t'(a) * dadda_pkg::product_t'(b);
        wb_write(adr_operands, {b, a});
        wb_read(adr_product, rdat);
        check_product("product", expected, rdat);
    endtask

    task automatic test_reset_state();
        dadda_pkg::wb_data_t rdat;
        wb_read(adr_operands, rdat);
        check_data("operands", '0, rdat);
        wb_read(adr_product, rdat);
        check_data("product", '0, rdat);
        wb_read(adr_status, rdat);
        check_data("status", '0, rdat);
        report_test("reset_state");
    endtask

    task automatic test_corner_products();
        multiply_and_check(16'h0000, 16'h0000);
        multiply_and_check(16'hffff, 16'hffff);
        multiply_and_check(16'h0001, 16'h1234);
        multiply_and_check(16'hbeef, 16'h0001);
        multiply_and_check(16'h0001, 16'hffff);
        multiply_and_check(16'h5555, 16'haaaa);
        for (int i = 0; i < 16; i++) begin
            multiply_and_check(16'h1 << i, 16'hffff);
            multiply_and_check(16'hffff, 16'h1 << i);
            multiply_and_check(16'h1 << i, 16'h8000 >> i);
        end
        report_test("corner_products");
    endtask

    task automatic test_random_products();
        dadda_pkg::operand_t a;
        dadda_pkg::operand_t b;
        for (int n = 0; n < n_random; n++) begin
            a = dadda_pkg::operand_t'($random(seed));
            b = dadda_pkg::operand_t'($random(seed));
            multiply_and_check(a, b);
        end
        report_test("random_products");
    endtask

    task automatic test_back_pressure();
        dadda_pkg::wb_data_t rdat;
        multiply_and_check(16'h1234, 16'h5678);
        // a new product must replace the old one even when read at once
        multiply_and_check(16'h0003, 16'h0007);
        // second write lands while the first product is still in flight
        wb_write(adr_operands, {16'h0100, 16'h0011});
        wb_write(adr_operands, {16'h00ff, 16'h0101});
        wb_read(adr_product, rdat);
        check_product("product", 32'h0000_ffff, rdat);
        report_test("back_pressure");
    endtask

    task automatic test_status_flags();
        dadda_pkg::wb_data_t rdat;
        wb_write(adr_operands, {16'h0040, 16'h0020});
        wb_read(adr_status, rdat);
        check_data("status", status_busy, rdat);
        wb_read(adr_product, rdat);
        check_product("product", 32'h0000_0800, rdat);
        wb_read(adr_status, rdat);
        check_data("status", status_done, rdat);
        report_test("status_flags");
    endtask

    task automatic test_readback_and_read_only();
        dadda_pkg::wb_data_t rdat;
        multiply_and_check(16'hc0de, 16'h0f0f);
        wb_read(adr_operands, rdat);
        check_data("operands", 32'h0f0f_c0de, rdat);
        wb_write(adr_product, 32'hdead_beef);
        wb_write(adr_status, 32'hffff_ffff);
        wb_read(adr_product, rdat);
        check_product("product", 32'h0b58_4f02, rdat);
        wb_read(adr_status, rdat);
        check_data("status", status_done, rdat);
        wb_read(adr_operands, rdat);
        check_data("operands", 32'h0f0f_c0de, rdat);
        wb_read(adr_unused, rdat);
        check_data("unused", '0, rdat);
        report_test("readback_and_read_only");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_wdat     = '0;
        errors      = 0;
        checks      = 0;
        errors_base = 0;
        cycle_count = 0;
        seed        = 32'hf81c;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_corner_products();
        test_random_products();
        test_back_pressure();
        test_status_flags();
        test_readback_and_read_only();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
dadda_pkg.sv
mul_core_if.sv
partial_product_gen.sv
dadda_reduce_stage.sv
dadda_tree.sv
cla_adder.sv
dadda_mult_core.sv
dadda_wb_slave.sv
dadda_mult_top.sv
tb_dadda_mult.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= filelist.f
TB_TOP    ?= tb_dadda_mult
RTL_TOP   ?= dadda_mult_top
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?=

COMMON_FLAGS = --timing --timescale $(TIMESCALE) -f $(FILELIST) $(VFLAGS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(COMMON_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

run: build
	@out=$$(./$(BUILD_DIR)/V$(TB_TOP)); echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

lint:
	$(VERILATOR) --lint-only $(COMMON_FLAGS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
